//--- common/ctrl_params.svh
////////////////////
// Board control parameters
// Bus widths, register count and readback word map
////////////////////

`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// Wishbone data width
`define CTRL_DW 32

// Wishbone byte address width
`define CTRL_AW 16

// Settings bus address width
`define CTRL_SET_AW 8

// Setting registers on the settings bus
`define CTRL_NUM_REGS 6

////////////////////
// Readback word map

// Words 0 to 5 hold the register values
`define CTRL_RB_COMPAT 6
`define CTRL_RB_CYCLES 7

// Bump when the FPGA changes enough to matter to software
`define CTRL_COMPAT_NUM 3

`endif

//--- common/ctrl_pkg.sv
////////////////////
// Board control types
// Bus word types and per-register width and reset tables
////////////////////

`include "ctrl_params.svh"

`default_nettype none

package ctrl_pkg;

   // Wishbone side
   typedef logic [`CTRL_DW-1:0] wb_data_t;
   typedef logic [`CTRL_AW-1:0] wb_addr_t;

   // Settings bus side
   typedef logic [`CTRL_SET_AW-1:0] set_addr_t;
   typedef logic [7:0] reg_val_t;

   ////////////////////
   // Register tables, indexed by settings address

   // Implemented bits per register, PHY reset is a single bit
   localparam int reg_width_tbl [`CTRL_NUM_REGS] = '{8, 8, 8, 8, 1, 8};

   // LED source comes up with the status LEDs under hardware control
   localparam reg_val_t reg_reset_tbl [`CTRL_NUM_REGS] = '{
      8'h00,
      8'h00,
      8'h00,
      8'h00,
      8'h00,
      8'h1E
   };

endpackage

`default_nettype wire

//--- common/wb_if.sv
////////////////////
// Wishbone bus
// Classic single-beat handshake, one master and one slave
////////////////////

`timescale 1ns/1ps
`default_nettype none

interface wb_if import ctrl_pkg::*; ();

   // Request side
   logic     cyc;
   logic     stb;
   logic     we;
   wb_addr_t adr;
   wb_data_t dat_w;

   // Response side
   wb_data_t dat_r;
   logic     ack;

   modport master (
      output cyc, stb, we, adr, dat_w,
      input  dat_r, ack
   );

   modport slave (
      input  cyc, stb, we, adr, dat_w,
      output dat_r, ack
   );

endinterface

`default_nettype wire

//--- hdl/settings_bus.sv
////////////////////
// Settings bus bridge
// Wishbone slave, turns writes into settings strobes
////////////////////

`timescale 1ns/1ps
`default_nettype none

module settings_bus import ctrl_pkg::*; (
   input  wire logic     wb_clk,
   input  wire logic     wb_rst,
   wb_if.slave           bus,
   input  wire wb_data_t rb_word_i,
   output logic          set_stb_o,
   output set_addr_t     set_addr_o,
   output reg_val_t      set_data_o
);

   logic     req_q;
   logic     ack_q;
   wb_data_t dat_r_q;
   logic     take;

   // New request only when nothing is pending or being acked
   assign take = bus.cyc & bus.stb & ~req_q & ~ack_q;

   ////////////////////
   // Handshake

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         req_q     <= 1'b0;
         ack_q     <= 1'b0;
         set_stb_o <= 1'b0;
      end else begin
         req_q     <= take;
         ack_q     <= req_q;
         set_stb_o <= req_q & bus.we;
      end
   end

   // Payload, master holds it stable until ack
   always_ff @(posedge wb_clk) begin
      if (req_q & bus.we) begin
         set_addr_o <= bus.adr[9:2];
         set_data_o <= bus.dat_w[$bits(reg_val_t)-1:0];
      end
      if (req_q & ~bus.we) begin
         dat_r_q <= rb_word_i;
      end
   end

   assign bus.ack   = ack_q;
   assign bus.dat_r = dat_r_q;

endmodule

`default_nettype wire

//--- hdl/setting_reg.sv
////////////////////
// Setting register
// One settings-bus address, masked to its width
////////////////////

`timescale 1ns/1ps
`default_nettype none

module setting_reg import ctrl_pkg::*; #(
   parameter int REG_IDX = 0
) (
   input  wire logic      wb_clk,
   input  wire logic      wb_rst,
   input  wire logic      set_stb_i,
   input  wire set_addr_t set_addr_i,
   input  wire reg_val_t  set_data_i,
   output reg_val_t       value_o,
   output logic           changed_o
);

   // Bits this register actually keeps
   localparam int       WIDTH = reg_width_tbl[REG_IDX];
   localparam reg_val_t MASK  = reg_val_t'((1 << WIDTH) - 1);

   logic hit;

   assign hit = set_stb_i && (set_addr_i == set_addr_t'(REG_IDX));

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         value_o   <= reg_reset_tbl[REG_IDX];
         changed_o <= 1'b0;
      end else begin
         // One-cycle pulse alongside the new value
         changed_o <= hit;
         if (hit) begin
            value_o <= set_data_i & MASK;
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/reg_fanout.sv
////////////////////
// Register fanout
// Control pins, LED merge and readback word mux
////////////////////

`timescale 1ns/1ps
`include "ctrl_params.svh"
`default_nettype none

module reg_fanout import ctrl_pkg::*; (
   input  wire logic                      wb_clk,
   input  wire logic                      wb_rst,
   input  wire reg_val_t                  values_i [`CTRL_NUM_REGS],
   input  wire logic [`CTRL_NUM_REGS-1:0] changed_i,
   input  wire logic [3:0]                rb_idx_i,
   input  wire logic                      clk_status_i,
   input  wire logic                      serdes_link_up_i,
   input  wire logic                      run_rx_i,
   input  wire logic                      run_tx_i,
   output wb_data_t                       rb_word_o,
   output logic                           cfg_update_o,
   output logic [7:0]                     leds_o,
   output logic                           clock_ready_o,
   output logic [1:0]                     clk_en_o,
   output logic [1:0]                     clk_sel_o,
   output logic                           ser_enable_o,
   output logic                           ser_prbsen_o,
   output logic                           ser_loopen_o,
   output logic                           ser_rx_en_o,
   output logic                           adc_oe_a_o,
   output logic                           adc_on_a_o,
   output logic                           adc_oe_b_o,
   output logic                           adc_on_b_o,
   output logic                           phy_reset_n_o
);

   localparam int REG_CLK     = 0;
   localparam int REG_SERDES  = 1;
   localparam int REG_ADC     = 2;
   localparam int REG_LED_SW  = 3;
   localparam int REG_PHY     = 4;
   localparam int REG_LED_SRC = 5;

   reg_val_t led_hw;
   wb_data_t cycle_cnt;

   ////////////////////
   // Control pins

   assign {clock_ready_o, clk_en_o, clk_sel_o} = values_i[REG_CLK][4:0];
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = values_i[REG_SERDES][3:0];
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = values_i[REG_ADC][3:0];
   assign phy_reset_n_o = ~values_i[REG_PHY][0];

   // Source bit set means hardware drives that LED
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i, 1'b0};
   assign leds_o = (values_i[REG_LED_SRC] & led_hw) |
                   (~values_i[REG_LED_SRC] & values_i[REG_LED_SW]);

   assign cfg_update_o = |changed_i;

   ////////////////////
   // Readback

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         cycle_cnt <= '0;
      end else begin
         cycle_cnt <= cycle_cnt + 1'b1;
      end
   end

   always_comb begin
      rb_word_o = '0;
      for (int i = 0; i < `CTRL_NUM_REGS; i++) begin
         if (rb_idx_i == 4'(i)) begin
            rb_word_o = wb_data_t'(values_i[i]);
         end
      end
      if (rb_idx_i == 4'(`CTRL_RB_COMPAT)) begin
         rb_word_o = wb_data_t'(`CTRL_COMPAT_NUM);
      end
      if (rb_idx_i == 4'(`CTRL_RB_CYCLES)) begin
         rb_word_o = cycle_cnt;
      end
   end

endmodule

`default_nettype wire

//--- hdl/ctrl_core.sv
////////////////////
// Board control core
// Wishbone settings bus, setting registers and pin fanout
////////////////////

`timescale 1ns/1ps
`include "ctrl_params.svh"
`default_nettype none

module ctrl_core import ctrl_pkg::*; (
   input  wire logic     wb_clk,
   input  wire logic     wb_rst,

   // Wishbone slave
   input  wire wb_addr_t wb_adr_i,
   input  wire wb_data_t wb_dat_i,
   input  wire logic     wb_we_i,
   input  wire logic     wb_stb_i,
   input  wire logic     wb_cyc_i,
   output wb_data_t      wb_dat_o,
   output logic          wb_ack_o,

   // Board status
   input  wire logic     clk_status_i,
   input  wire logic     serdes_link_up_i,
   input  wire logic     run_rx_i,
   input  wire logic     run_tx_i,

   // Board control
   output logic          cfg_update_o,
   output logic [7:0]    leds_o,
   output logic          clock_ready_o,
   output logic [1:0]    clk_en_o,
   output logic [1:0]    clk_sel_o,
   output logic          ser_enable_o,
   output logic          ser_prbsen_o,
   output logic          ser_loopen_o,
   output logic          ser_rx_en_o,
   output logic          adc_oe_a_o,
   output logic          adc_on_a_o,
   output logic          adc_oe_b_o,
   output logic          adc_on_b_o,
   output logic          phy_reset_n_o
);

   wb_if bus ();

   logic      set_stb;
   set_addr_t set_addr;
   reg_val_t  set_data;
   wb_data_t  rb_word;

   wire reg_val_t                  reg_vals [`CTRL_NUM_REGS];
   wire logic [`CTRL_NUM_REGS-1:0] reg_changed;

   assign bus.cyc   = wb_cyc_i;
   assign bus.stb   = wb_stb_i;
   assign bus.we    = wb_we_i;
   assign bus.adr   = wb_adr_i;
   assign bus.dat_w = wb_dat_i;
   assign wb_dat_o  = bus.dat_r;
   assign wb_ack_o  = bus.ack;

   settings_bus i_settings_bus (
      .wb_clk     (wb_clk),
      .wb_rst     (wb_rst),
      .bus        (bus.slave),
      .rb_word_i  (rb_word),
      .set_stb_o  (set_stb),
      .set_addr_o (set_addr),
      .set_data_o (set_data)
   );

   ////////////////////
   // Setting registers

   for (genvar g = 0; g < `CTRL_NUM_REGS; g++) begin : g_reg
      setting_reg #(
         .REG_IDX (g)
      ) i_setting_reg (
         .wb_clk     (wb_clk),
         .wb_rst     (wb_rst),
         .set_stb_i  (set_stb),
         .set_addr_i (set_addr),
         .set_data_i (set_data),
         .value_o    (reg_vals[g]),
         .changed_o  (reg_changed[g])
      );
   end

   // Readback word picked by byte address bits 5 to 2
   reg_fanout i_reg_fanout (
      .wb_clk           (wb_clk),
      .wb_rst           (wb_rst),
      .values_i         (reg_vals),
      .changed_i        (reg_changed),
      .rb_idx_i         (bus.adr[5:2]),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .run_rx_i         (run_rx_i),
      .run_tx_i         (run_tx_i),
      .rb_word_o        (rb_word),
      .cfg_update_o     (cfg_update_o),
      .leds_o           (leds_o),
      .clock_ready_o    (clock_ready_o),
      .clk_en_o         (clk_en_o),
      .clk_sel_o        (clk_sel_o),
      .ser_enable_o     (ser_enable_o),
      .ser_prbsen_o     (ser_prbsen_o),
      .ser_loopen_o     (ser_loopen_o),
      .ser_rx_en_o      (ser_rx_en_o),
      .adc_oe_a_o       (adc_oe_a_o),
      .adc_on_a_o       (adc_on_a_o),
      .adc_oe_b_o       (adc_oe_b_o),
      .adc_on_b_o       (adc_on_b_o),
      .phy_reset_n_o    (phy_reset_n_o)
   );

endmodule

`default_nettype wire

//--- sim/ctrl_core_asserts.sv
////////////////////
// Control core checks
// Bus handshake and write pulse timing
////////////////////

`timescale 1ns/1ps
`include "ctrl_params.svh"
`default_nettype none

module ctrl_core_asserts import ctrl_pkg::*; (
   input wire logic     wb_clk,
   input wire logic     wb_rst,
   input wire logic     wb_we_i,
   input wire wb_addr_t wb_adr_i,
   input wire logic     wb_ack_o,
   input wire logic     cfg_update_o
);

   logic write_hit;

   // Failed checks so far, read by the testbench
   int fail_count = 0;

   // Acked write that lands on one of the setting registers
   assign write_hit = wb_ack_o && wb_we_i && (wb_adr_i[9:2] < 8'(`CTRL_NUM_REGS));

   ack_single: assert property (@(posedge wb_clk) disable iff (wb_rst)
      wb_ack_o |=> !wb_ack_o)
      else begin
         $error("ack high two cycles in a row");
         fail_count++;
      end

   pulse_after_write: assert property (@(posedge wb_clk) disable iff (wb_rst)
      write_hit |=> cfg_update_o)
      else begin
         $error("no write pulse after register write");
         fail_count++;
      end

   no_stray_pulse: assert property (@(posedge wb_clk) disable iff (wb_rst)
      !write_hit |=> !cfg_update_o)
      else begin
         $error("write pulse without register write");
         fail_count++;
      end

endmodule

`default_nettype wire

//--- sim/tb_ctrl_core.sv
////////////////////
// Control core testbench
// Runs the stimulus file against the bus and pins
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_ctrl_core import ctrl_pkg::*; ();

   localparam int MAX_TESTS = 64;

   logic       wb_clk;
   logic       wb_rst;
   wb_addr_t   wb_adr_i;
   wb_data_t   wb_dat_i;
   logic       wb_we_i;
   logic       wb_stb_i;
   logic       wb_cyc_i;
   wb_data_t   wb_dat_o;
   logic       wb_ack_o;
   logic       clk_status_i;
   logic       serdes_link_up_i;
   logic       run_rx_i;
   logic       run_tx_i;
   logic       cfg_update_o;
   logic [7:0] leds_o;
   logic       clock_ready_o;
   logic [1:0] clk_en_o;
   logic [1:0] clk_sel_o;
   logic       ser_enable_o;
   logic       ser_prbsen_o;
   logic       ser_loopen_o;
   logic       ser_rx_en_o;
   logic       adc_oe_a_o;
   logic       adc_on_a_o;
   logic       adc_oe_b_o;
   logic       adc_on_b_o;
   logic       phy_reset_n_o;

   // Stimulus table
   string      test_name [MAX_TESTS];
   string      test_op [MAX_TESTS];
   wb_data_t   test_addr [MAX_TESTS];
   wb_data_t   test_data [MAX_TESTS];
   logic [3:0] test_hw [MAX_TESTS];
   wb_data_t   test_exp [MAX_TESTS];
   int         num_tests;

   int         cycle_count = 0;
   int         cycle_limit = 100000;
   int         pulse_count = 0;
   int         pulses_expected;
   wb_data_t   rd_data;
   wb_data_t   prev_count;
   logic       have_count;

   ctrl_core i_ctrl_core (.*);

   bind ctrl_core ctrl_core_asserts i_ctrl_core_asserts (
      .wb_clk       (wb_clk),
      .wb_rst       (wb_rst),
      .wb_we_i      (wb_we_i),
      .wb_adr_i     (wb_adr_i),
      .wb_ack_o     (wb_ack_o),
      .cfg_update_o (cfg_update_o)
   );

   initial begin
      wb_clk = 1'b0;
      forever #5 wb_clk = ~wb_clk;
   end

   always @(posedge wb_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout: test did not finish within %0d cycles", cycle_limit);
         $display("sim failed");
         $fatal(1, "run stopped on timeout");
      end
   end

   // Write pulses seen on the pin
   always @(negedge wb_clk) begin
      if (!wb_rst && cfg_update_o) begin
         pulse_count <= pulse_count + 1;
      end
   end

   // Bound checks on the handshake and write pulse
   always @(negedge wb_clk) begin
      assert (i_ctrl_core.i_ctrl_core_asserts.fail_count == 0) else begin
         $display("a bound assertion on the bus handshake or write pulse failed");
         $display("sim failed");
         $fatal(1, "run stopped on assertion failure");
      end
   end

   task automatic check_value(input string name, input wb_data_t expected,
                              input wb_data_t actual);
      assert (actual === expected) else begin
         $display("ERR %s expected %h actual %h", name, expected, actual);
         $display("sim failed");
         $fatal(1, "run stopped at first error");
      end
   endtask

   // One Wishbone transfer, then one idle cycle with stb low
   task automatic run_bus(input logic we, input wb_data_t adr, input wb_data_t dat);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = wb_addr_t'(adr);
      wb_dat_i = dat;
      @(negedge wb_clk);
      while (!wb_ack_o) begin
         @(negedge wb_clk);
      end
      rd_data  = wb_dat_o;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      @(negedge wb_clk);
   endtask

   // Pin groups: 0 clock, 1 SERDES, 2 ADC, 3 PHY reset, 4 LEDs
   function automatic wb_data_t pin_group(input wb_data_t sel);
      case (sel)
         0:       pin_group = wb_data_t'({clock_ready_o, clk_en_o, clk_sel_o});
         1:       pin_group = wb_data_t'({ser_enable_o, ser_prbsen_o, ser_loopen_o,
                                          ser_rx_en_o});
         2:       pin_group = wb_data_t'({adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o});
         3:       pin_group = wb_data_t'(phy_reset_n_o);
         4:       pin_group = wb_data_t'(leds_o);
         default: pin_group = '0;
      endcase
   endfunction

   task automatic load_stimulus();
      int                 fd;
      int                 code;
      string              tok;
      string              op;
      wb_data_t           addr;
      wb_data_t           data;
      wb_data_t           hw;
      wb_data_t           exp;
      logic [8*256-1:0]   rest;
      fd = $fopen("sim/ctrl_stim.txt", "r");
      if (fd == 0) begin
         $display("cannot open the stimulus file sim/ctrl_stim.txt");
         $display("sim failed");
         $fatal(1, "no stimulus");
      end
      num_tests = 0;
      while ($fscanf(fd, "%s", tok) == 1) begin
         if (tok == "#") begin
            code = $fgets(rest, fd);
         end else begin
            code = $fscanf(fd, "%s %h %h %h %h", op, addr, data, hw, exp);
            if (code != 5 || num_tests >= MAX_TESTS) begin
               $display("stimulus line %s is malformed or the table is full", tok);
               $display("sim failed");
               $fatal(1, "bad stimulus");
            end
            test_name[num_tests] = tok;
            test_op[num_tests]   = op;
            test_addr[num_tests] = addr;
            test_data[num_tests] = data;
            test_hw[num_tests]   = hw[3:0];
            test_exp[num_tests]  = exp;
            num_tests++;
         end
      end
      $fclose(fd);
   endtask

   initial begin
      wb_rst           = 1'b1;
      wb_adr_i         = '0;
      wb_dat_i         = '0;
      wb_we_i          = 1'b0;
      wb_stb_i         = 1'b0;
      wb_cyc_i         = 1'b0;
      clk_status_i     = 1'b0;
      serdes_link_up_i = 1'b0;
      run_rx_i         = 1'b0;
      run_tx_i         = 1'b0;
      pulses_expected  = 0;
      have_count       = 1'b0;
      prev_count       = '0;
      load_stimulus();
      cycle_limit = 20 * num_tests + 100;

      repeat (16) @(negedge wb_clk);
      wb_rst = 1'b0;
      @(negedge wb_clk);

      for (int i = 0; i < num_tests; i++) begin
         {run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i} = test_hw[i];
         if (test_op[i] == "w") begin
            // Idle cycle after ack carries the write pulse
            run_bus(1'b1, test_addr[i], test_data[i]);
            check_value(test_name[i], test_exp[i], wb_data_t'(cfg_update_o));
            if (test_exp[i] != 0) begin
               pulses_expected++;
            end
         end else if (test_op[i] == "r") begin
            run_bus(1'b0, test_addr[i], '0);
            check_value(test_name[i], test_exp[i], rd_data);
         end else if (test_op[i] == "p") begin
            @(negedge wb_clk);
            check_value(test_name[i], test_exp[i], pin_group(test_addr[i]));
         end else if (test_op[i] == "c") begin
            run_bus(1'b0, test_addr[i], '0);
            if (have_count) begin
               assert (rd_data > prev_count) else begin
                  $display("ERR %s expected above %h actual %h", test_name[i],
                           prev_count, rd_data);
                  $display("sim failed");
                  $fatal(1, "run stopped at first error");
               end
            end
            prev_count = rd_data;
            have_count = 1'b1;
         end else begin
            $display("unknown operation %s in test %s", test_op[i], test_name[i]);
            $display("sim failed");
            $fatal(1, "bad stimulus");
         end
      end

      @(negedge wb_clk);
      check_value("pulse_count", wb_data_t'(pulses_expected), wb_data_t'(pulse_count));
      if (i_ctrl_core.i_ctrl_core_asserts.fail_count == 0) begin
         $display("sim passed");
         $finish;
      end else begin
         $display("a bound assertion on the bus handshake or write pulse failed");
         $display("sim failed");
         $fatal(1, "run stopped on assertion failure");
      end
   end

endmodule

`default_nettype wire

//--- sim/ctrl_stim.txt
# name op addr data hw expected (hex); op w write, r read, p pin group, c counter read
# w expects the write pulse, p groups 0 clock 1 serdes 2 adc 3 phy_reset_n 4 leds
rst_clk      r 0000 00000000 0 00000000
rst_serdes   r 0004 00000000 0 00000000
rst_adc      r 0008 00000000 0 00000000
rst_led_sw   r 000C 00000000 0 00000000
rst_phy      r 0010 00000000 0 00000000
rst_led_src  r 0014 00000000 0 0000001E
rst_compat   r 0018 00000000 0 00000003
rst_phy_pin  p 0003 00000000 0 00000001
wr_phy       w 0010 000000FF 0 00000001
rd_phy       r 0010 00000000 0 00000001
pin_phy      p 0003 00000000 0 00000000
wr_clk       w 0000 00001234 0 00000001
rd_clk       r 0000 00000000 0 00000034
pin_clk      p 0000 00000000 0 00000014
wr_serdes    w 0004 0000005A 0 00000001
pin_serdes   p 0001 00000000 0 0000000A
wr_adc       w 0008 00000036 0 00000001
pin_adc      p 0002 00000000 0 00000006
rd_adc       r 0008 00000000 0 00000036
wr_phy_clr   w 0010 00000002 0 00000001
pin_phy_clr  p 0003 00000000 0 00000001
rd_word8     r 0020 00000000 0 00000000
rd_word11    r 002C 00000000 0 00000000
rd_word15    r 003C 00000000 0 00000000
wr_led_sw    w 000C 000000A5 F 00000001
led_hw_all   p 0004 00000000 F 000000BF
led_hw_part  p 0004 00000000 5 000000AB
wr_led_src   w 0014 00000003 F 00000001
rd_led_src   r 0014 00000000 F 00000003
led_src_low  p 0004 00000000 F 000000A6
wr_word7     w 001C 000000FF 0 00000000
rd_cnt_a     c 001C 00000000 0 00000000
rd_cnt_b     c 001C 00000000 0 00000000

//--- verilog.f
+incdir+common
common/ctrl_pkg.sv
common/wb_if.sv
hdl/settings_bus.sv
hdl/setting_reg.sv
hdl/reg_fanout.sv
hdl/ctrl_core.sv
sim/ctrl_core_asserts.sv
sim/tb_ctrl_core.sv

//--- Bender.yml
package:
  name: ctrl_core

sources:
  - include_dirs:
      - common
    files:
      - common/ctrl_pkg.sv
      - common/wb_if.sv
      - hdl/settings_bus.sv
      - hdl/setting_reg.sv
      - hdl/reg_fanout.sv
      - hdl/ctrl_core.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/ctrl_core_asserts.sv
      - sim/tb_ctrl_core.sv
